// ==== logic/freelist_params.svh ====
// Freelist tracker sizing
// Pool size, offer width, return ports and count latency

`ifndef FREELIST_PARAMS_SVH
`define FREELIST_PARAMS_SVH

// Number of IDs in the pool
`define FREELIST_NUM_ENTRIES 8

// Offer slots per cycle, kept below the pool size
`define FREELIST_ALLOC_PER_CYCLE 2

// Return ports, each with its own valid strobe
`define FREELIST_DEALLOC_PORTS 2

// Cycles from a return to its appearance on dealloc_count
// Must be at least 1
`define FREELIST_DEALLOC_COUNT_DELAY 2

`endif

// ==== logic/freelist_pkg.sv ====
// Freelist tracker types
// Entry IDs, masks, counts and the offer and return bundles

`include "freelist_params.svh"

package freelist_pkg;

  // One entry ID
  typedef logic [$clog2(`FREELIST_NUM_ENTRIES)-1:0] entry_id_t;

  // One bit per entry
  // Used for the free bitmap and for take and return masks
  typedef logic [`FREELIST_NUM_ENTRIES-1:0] entry_mask_t;

  // Offered or accepted slot count, 0 up to the offer width
  typedef logic [$clog2(`FREELIST_ALLOC_PER_CYCLE+1)-1:0] alloc_count_t;

  // Returns seen in one cycle, 0 up to the port count
  typedef logic [$clog2(`FREELIST_DEALLOC_PORTS+1)-1:0] dealloc_count_t;

  // Offer toward the consumer
  // Slot 0 carries the lowest free ID, slot 1 the next one up
  // Only slots below sendable hold a meaningful ID
  typedef struct packed {
    alloc_count_t                                    sendable;
    entry_id_t [`FREELIST_ALLOC_PER_CYCLE-1:0]       entry_id;
  } alloc_offer_t;

  // Returns from the consumer
  // One valid bit and one ID per port
  typedef struct packed {
    logic      [`FREELIST_DEALLOC_PORTS-1:0]         valid;
    entry_id_t [`FREELIST_DEALLOC_PORTS-1:0]         entry_id;
  } dealloc_req_t;

endpackage

// ==== logic/freelist_alloc_select.sv ====
// Freelist offer selection
// Picks the lowest free entries for the offer slots and marks the ones taken

`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_alloc_select
  import freelist_pkg::*;
(
  input  entry_mask_t  free_mask,
  input  alloc_count_t alloc_receivable,
  output alloc_offer_t alloc_offer,
  output entry_mask_t  take_mask
);

  localparam int NUM_SLOTS = `FREELIST_ALLOC_PER_CYCLE;

  // Entries still available to each slot after the lower slots took theirs
  entry_mask_t [NUM_SLOTS-1:0] avail;
  // One-hot pick per slot, zero when nothing is left
  entry_mask_t [NUM_SLOTS-1:0] pick;
  entry_id_t   [NUM_SLOTS-1:0] slot_id;
  logic        [NUM_SLOTS-1:0] slot_found;
  // Slot is below the consumer's accepted count
  logic        [NUM_SLOTS-1:0] slot_take;
  alloc_count_t                offer_count;

  // Isolate the lowest set bit
  function automatic entry_mask_t lowest_onehot(input entry_mask_t mask);
    return mask & (~mask + entry_mask_t'(1));
  endfunction

  // Encode a one-hot (or empty) mask to an ID
  function automatic entry_id_t onehot_to_id(input entry_mask_t onehot);
    entry_id_t id;
    id = '0;
    for (int e = 0; e < `FREELIST_NUM_ENTRIES; e++) begin
      if (onehot[e]) begin
        id = id | entry_id_t'(e);
      end
    end
    return id;
  endfunction

  for (genvar s = 0; s < NUM_SLOTS; s++) begin : gen_slot
    // Slot 0 sees the whole bitmap, later slots skip what earlier slots picked
    if (s == 0) begin : gen_first
      assign avail[s] = free_mask;
    end else begin : gen_next
      assign avail[s] = avail[s-1] & ~pick[s-1];
    end

    assign pick[s]       = lowest_onehot(avail[s]);
    assign slot_found[s] = |avail[s];
    assign slot_id[s]    = onehot_to_id(pick[s]);
    assign slot_take[s]  = slot_found[s] && (alloc_count_t'(s) < alloc_receivable);
  end

  // Found slots are always contiguous from slot 0, so a popcount gives sendable
  always_comb begin
    offer_count = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      offer_count = offer_count + alloc_count_t'(slot_found[s]);
    end
  end

  // Entries leaving the pool this cycle
  always_comb begin
    take_mask = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (slot_take[s]) begin
        take_mask = take_mask | pick[s];
      end
    end
  end

  // Offer depends on the bitmap alone, never on alloc_receivable
  assign alloc_offer = '{sendable: offer_count, entry_id: slot_id};

endmodule

// ==== logic/freelist_dealloc_count.sv ====
// Freelist return counter
// Counts valid returns per cycle and delays the count by a fixed latency

`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_dealloc_count
  import freelist_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  dealloc_req_t   dealloc_req,
  output dealloc_count_t dealloc_count
);

  localparam int DELAY = `FREELIST_DEALLOC_COUNT_DELAY;

  // Returns seen this cycle
  dealloc_count_t                 count_now;
  // Delay line, stage 0 is one cycle old
  dealloc_count_t [DELAY-1:0]     count_pipe;

  always_comb begin
    count_now = '0;
    for (int p = 0; p < `FREELIST_DEALLOC_PORTS; p++) begin
      count_now = count_now + dealloc_count_t'(dealloc_req.valid[p]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Count stays 0 until real returns have crossed the whole chain
      count_pipe <= '0;
    end else begin
      count_pipe[0] <= count_now;
      for (int i = 1; i < DELAY; i++) begin
        count_pipe[i] <= count_pipe[i-1];
      end
    end
  end

  // Oldest stage: returns from DELAY cycles back
  assign dealloc_count = count_pipe[DELAY-1];

endmodule

// ==== logic/freelist_tracker.sv ====
// Freelist tracker top level
// Keeps the free bitmap, offers the lowest free IDs and takes returns
// Reports returned IDs as a delayed count for credit-based requesters

`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_tracker
  import freelist_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  // Allocation side
  input  alloc_count_t   alloc_receivable,
  output alloc_offer_t   alloc_offer,
  // Return side
  input  dealloc_req_t   dealloc_req,
  output dealloc_count_t dealloc_count
);

  // One bit per entry, set while the entry is free
  entry_mask_t free_mask;
  // Entries actually allocated this cycle
  entry_mask_t take_mask;
  // Entries coming back this cycle
  entry_mask_t return_mask;
  entry_mask_t free_mask_next;

  // Offer and take selection
  // Offer is driven from the registered bitmap only
  freelist_alloc_select u_alloc_select (
    .free_mask        (free_mask),
    .alloc_receivable (alloc_receivable),
    .alloc_offer      (alloc_offer),
    .take_mask        (take_mask)
  );

  // Decode the return ports into a mask
  // Ports are assumed to carry distinct, currently allocated IDs
  always_comb begin
    return_mask = '0;
    for (int p = 0; p < `FREELIST_DEALLOC_PORTS; p++) begin
      if (dealloc_req.valid[p]) begin
        return_mask[dealloc_req.entry_id[p]] = 1'b1;
      end
    end
  end

  // Taken entries leave, returned entries come back
  // A legal return never names an ID that is free, so the two masks
  // never overlap and the order of clear and set does not matter
  assign free_mask_next = (free_mask & ~take_mask) | return_mask;

  always_ff @(posedge clk) begin
    if (rst) begin
      // Whole pool free after reset
      free_mask <= '1;
    end else begin
      free_mask <= free_mask_next;
    end
  end

  // Delayed return count
  freelist_dealloc_count u_dealloc_count (
    .clk           (clk),
    .rst           (rst),
    .dealloc_req   (dealloc_req),
    .dealloc_count (dealloc_count)
  );

endmodule

// ==== test/freelist_tracker_properties.sv ====
// Freelist tracker properties
// Concurrent checks bound into the tracker for offer, take and count timing

`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_tracker_properties
  import freelist_pkg::*;
(
  input logic           clk,
  input logic           rst,
  input alloc_count_t   alloc_receivable,
  input alloc_offer_t   alloc_offer,
  input dealloc_req_t   dealloc_req,
  input dealloc_count_t dealloc_count,
  input entry_mask_t    free_mask,
  input entry_mask_t    take_mask
);

  localparam int DELAY = `FREELIST_DEALLOC_COUNT_DELAY;

  // Returns seen in the current cycle
  dealloc_count_t return_count;
  // Slots actually allocated, the smaller of offer and accept
  alloc_count_t   accept_count;

  assign return_count = dealloc_count_t'($countones(dealloc_req.valid));
  assign accept_count = (alloc_offer.sendable < alloc_receivable) ?
                        alloc_offer.sendable : alloc_receivable;

  // Two filled slots never carry the same ID
  offer_ids_distinct: assert property (@(posedge clk) disable iff (rst)
    (alloc_offer.sendable == alloc_count_t'(2)) |->
      (alloc_offer.entry_id[0] != alloc_offer.entry_id[1]))
    else $error("Offer slots carry the same entry ID");

  // Each accepted slot names a free entry, and that entry leaves the pool
  for (genvar s = 0; s < `FREELIST_ALLOC_PER_CYCLE; s++) begin : gen_slot_take
    taken_entry_was_free: assert property (@(posedge clk) disable iff (rst)
      (alloc_count_t'(s) < accept_count) |->
        (free_mask[alloc_offer.entry_id[s]] && take_mask[alloc_offer.entry_id[s]]))
      else $error("Accepted slot %0d names an entry that is not free or not taken", s);
  end

  // Nothing beyond the accepted slots leaves the pool
  take_count_matches_accept: assert property (@(posedge clk) disable iff (rst)
    ($countones(take_mask) == int'(accept_count)))
    else $error("Number of allocated entries differs from the accepted count");

  // Fully allocated pool offers nothing
  empty_pool_offers_none: assert property (@(posedge clk) disable iff (rst)
    (free_mask == '0) |-> (alloc_offer.sendable == '0))
    else $error("Empty pool still offers entries");

  // Count appears a fixed number of cycles after the returns
  // Only checked once the delay line has seen no reset
  count_follows_returns: assert property (@(posedge clk) disable iff (rst)
    ($past(!rst, 1) && $past(!rst, DELAY)) |->
      (dealloc_count == $past(return_count, DELAY)))
    else $error("Return count does not match the returns from the delayed cycle");

endmodule

bind freelist_tracker freelist_tracker_properties u_properties (
  .clk              (clk),
  .rst              (rst),
  .alloc_receivable (alloc_receivable),
  .alloc_offer      (alloc_offer),
  .dealloc_req      (dealloc_req),
  .dealloc_count    (dealloc_count),
  .free_mask        (free_mask),
  .take_mask        (take_mask)
);

// ==== test/freelist_tracker_tb.sv ====
// Freelist tracker testbench
// Table rows then random traffic, checked against a free-bitmap model

`timescale 1ns/10ps
`include "freelist_params.svh"

module freelist_tracker_tb
  import freelist_pkg::*;
;

  localparam int NUM_ENTRIES = `FREELIST_NUM_ENTRIES;
  localparam int NUM_SLOTS   = `FREELIST_ALLOC_PER_CYCLE;
  localparam int NUM_PORTS   = `FREELIST_DEALLOC_PORTS;
  localparam int NUM_ROWS    = 16;
  localparam int NUM_RANDOM  = 200;
  // Reset, table and random cycles plus a margin
  localparam int MAX_CYCLES  = 8 + NUM_ROWS + NUM_RANDOM + 20;

  // One cycle of stimulus with the hand-worked offer size
  typedef struct packed {
    alloc_count_t                    recv;
    logic      [NUM_PORTS-1:0]       ret_valid;
    entry_id_t [NUM_PORTS-1:0]       ret_id;
    alloc_count_t                    exp_sendable;
  } stim_row_t;

  logic           clk = 1'b0;
  logic           rst;
  alloc_count_t   alloc_receivable;
  alloc_offer_t   alloc_offer;
  dealloc_req_t   dealloc_req;
  dealloc_count_t dealloc_count;

  stim_row_t      table_rows [0:NUM_ROWS-1];
  stim_row_t      rand_row;
  // Model state, a set bit means free
  entry_mask_t    model_free;
  // Return counts, index 0 is one cycle old
  int             ret_hist [0:1];
  int             error_count = 0;
  int             check_count = 0;
  int             cycle_count = 0;
  integer         seed;

  freelist_tracker u_dut (
    .clk              (clk),
    .rst              (rst),
    .alloc_receivable (alloc_receivable),
    .alloc_offer      (alloc_offer),
    .dealloc_req      (dealloc_req),
    .dealloc_count    (dealloc_count)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  function automatic stim_row_t make_row(input int recv, input logic [1:0] vld,
                                         input int id1, input int id0, input int exp);
    stim_row_t row;
    row.recv         = alloc_count_t'(recv);
    row.ret_valid    = vld;
    row.ret_id[1]    = entry_id_t'(id1);
    row.ret_id[0]    = entry_id_t'(id0);
    row.exp_sendable = alloc_count_t'(exp);
    return row;
  endfunction

  task automatic check_equal(input string what, input int got, input int expected);
    check_count++;
    assert (got == expected) else begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      error_count++;
    end
  endtask

  // Starts 2 ns after a rising edge and returns at the same point one cycle on
  task automatic apply_cycle(input stim_row_t row, input bit use_table_exp);
    entry_id_t exp_id [0:NUM_SLOTS-1];
    int        exp_send;
    int        ret_count;
    exp_send  = 0;
    ret_count = 0;
    alloc_receivable = row.recv;
    dealloc_req      = '{valid: row.ret_valid, entry_id: row.ret_id};
    // Lowest free IDs in ascending order, at most one per slot
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (model_free[e] && exp_send < NUM_SLOTS) begin
        exp_id[exp_send] = entry_id_t'(e);
        exp_send++;
      end
    end
    @(negedge clk);
    check_equal("sendable", int'(alloc_offer.sendable), exp_send);
    if (use_table_exp) begin
      check_equal("sendable against table", int'(alloc_offer.sendable),
                  int'(row.exp_sendable));
    end
    for (int s = 0; s < exp_send; s++) begin
      check_equal("offered id", int'(alloc_offer.entry_id[s]), int'(exp_id[s]));
    end
    check_equal("dealloc_count", int'(dealloc_count), ret_hist[1]);
    // Take from the front of the offer, then return
    for (int s = 0; s < exp_send; s++) begin
      if (s < int'(row.recv)) begin
        model_free[exp_id[s]] = 1'b0;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (row.ret_valid[p]) begin
        model_free[row.ret_id[p]] = 1'b1;
        ret_count++;
      end
    end
    ret_hist[1] = ret_hist[0];
    ret_hist[0] = ret_count;
    @(posedge clk);
    #2;
  endtask

  // Random accept count and returns drawn from the allocated set
  task automatic build_random_row(output stim_row_t row);
    entry_id_t allocated [$];
    int        r;
    int        pick;
    row = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (!model_free[e]) begin
        allocated.push_back(entry_id_t'(e));
      end
    end
    row.recv = alloc_count_t'({$random(seed)} % (NUM_SLOTS + 1));
    for (int p = 0; p < NUM_PORTS; p++) begin
      r = $random(seed);
      if (r[0] && allocated.size() > 0) begin
        pick = {$random(seed)} % allocated.size();
        row.ret_valid[p] = 1'b1;
        row.ret_id[p]    = allocated[pick];
        allocated.delete(pick);
      end
    end
  endtask

  initial begin
    seed             = 32'h878e;
    rst              = 1'b1;
    alloc_receivable = '0;
    dealloc_req      = '0;
    model_free       = '1;
    ret_hist[0]      = 0;
    ret_hist[1]      = 0;
    // recv, return valids, port 1 ID, port 0 ID, expected sendable
    table_rows[0]  = make_row(0, 2'b00, 0, 0, 2);
    table_rows[1]  = make_row(1, 2'b00, 0, 0, 2);
    table_rows[2]  = make_row(1, 2'b00, 0, 0, 2);
    table_rows[3]  = make_row(2, 2'b00, 0, 0, 2);
    table_rows[4]  = make_row(2, 2'b00, 0, 0, 2);
    table_rows[5]  = make_row(2, 2'b00, 0, 0, 2);
    // Pool drained here
    table_rows[6]  = make_row(2, 2'b00, 0, 0, 0);
    table_rows[7]  = make_row(0, 2'b01, 0, 5, 0);
    table_rows[8]  = make_row(0, 2'b00, 0, 0, 1);
    table_rows[9]  = make_row(2, 2'b11, 3, 0, 1);
    table_rows[10] = make_row(1, 2'b10, 7, 0, 2);
    table_rows[11] = make_row(2, 2'b11, 2, 1, 2);
    table_rows[12] = make_row(2, 2'b11, 6, 4, 2);
    table_rows[13] = make_row(0, 2'b01, 0, 0, 2);
    table_rows[14] = make_row(1, 2'b10, 5, 0, 2);
    table_rows[15] = make_row(2, 2'b11, 1, 0, 2);

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    // First row also covers the state right after reset
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_cycle(table_rows[i], 1'b1);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      build_random_row(rand_row);
      apply_cycle(rand_row, 1'b0);
    end

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/freelist_pkg.sv
logic/freelist_alloc_select.sv
logic/freelist_dealloc_count.sv
logic/freelist_tracker.sv
test/freelist_tracker_properties.sv
test/freelist_tracker_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the freelist tracker simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module freelist_tracker_tb \
  -o freelist_tracker_sim

./obj_dir/freelist_tracker_sim | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
